// ==== src/rbz_pkg.sv ====
`default_nettype none

package rbz_pkg;

    // 640x480 at 25 MHz
    localparam logic [9:0] H_ACTIVE     = 10'd640;
    localparam logic [9:0] H_SYNC_START = 10'd656;
    localparam logic [9:0] H_SYNC_END   = 10'd752;
    localparam logic [9:0] H_TOTAL      = 10'd800;
    localparam logic [9:0] V_ACTIVE     = 10'd480;
    localparam logic [9:0] V_SYNC_START = 10'd490;
    localparam logic [9:0] V_SYNC_END   = 10'd492;
    localparam logic [9:0] V_TOTAL      = 10'd525;

    localparam logic [3:0] SPI_FRAME_BITS = 4'd12; // 4 address + 8 data

    typedef enum logic [3:0] {
        REG_MODE        = 4'd0,
        REG_FG          = 4'd1,
        REG_BG          = 4'd2,
        REG_CHECK_SHIFT = 4'd3
    } reg_addr_e;

    typedef enum logic [1:0] {
        RENDER_SOLID   = 2'd0, // Whole screen fg
        RENDER_BARS    = 2'd1,
        RENDER_CHECKER = 2'd2,
        RENDER_BG      = 2'd3  // Whole screen bg
    } render_mode_e;

    typedef struct packed {
        render_mode_e mode;
        logic [5:0]   fg;          // BGR222
        logic [5:0]   bg;          // BGR222
        logic [2:0]   check_shift; // Checker square is 2**check_shift pixels
    } render_cfg_t;

    localparam render_cfg_t RENDER_CFG_RESET = '{
        mode:        RENDER_SOLID,
        fg:          6'd0,
        bg:          6'd0,
        check_shift: 3'd3
    };

    typedef struct packed {
        logic [9:0] hpos;
        logic [9:0] vpos;
        logic       hblank;
        logic       vblank;
        logic       hsync_n;
        logic       vsync_n;
        logic       frame_start; // High for the single cycle at (0,0)
        logic       spare;       // Always 0
    } video_t;

    // Everything the debug selectors have in common
    typedef struct packed {
        logic        spi_csb;
        logic        spi_sclk;
        logic        spi_mosi;
        logic        hblank;
        logic        vblank;
        logic        hsync_n;
        logic        vsync_n;
        logic [9:0]  hpos;
        logic [9:0]  vpos;
        logic [23:0] rgb;      // Direct BGR888
    } probe_bus_t;

    typedef enum logic [5:0] {
        GP_PRIMARY   = 6'd0,
        GP_ALT       = 6'd1,
        GP_CLK       = 6'd2,
        GP_CLK_DIV4  = 6'd3,
        GP_SPI_CSB   = 6'd4,
        GP_SPI_SCLK  = 6'd5,
        GP_SPI_MOSI  = 6'd6,
        GP_RGB_BASE  = 6'd8,  // 8..31 give rgb[code-8]
        GP_HBLANK    = 6'd32,
        GP_VBLANK    = 6'd33,
        GP_HSYNC     = 6'd34,
        GP_VSYNC     = 6'd35,
        GP_HPOS_BASE = 6'd44, // 44..53 give hpos[code-44]
        GP_VPOS_BASE = 6'd54  // 54..63 give vpos[code-54]
    } gpout_sel_e;

    // bgr bit taken as primary by each gpout: G0 G1 R0 R1 B0 B1
    localparam int unsigned GP_PRIMARY_BIT [6] = '{2, 3, 0, 1, 4, 5};

endpackage

`default_nettype wire

// ==== src/vga_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_sync (
    input  logic            i_clk,
    input  logic            i_rbzero_reset,
    output rbz_pkg::video_t o_video
);

    logic [9:0] h_next;
    logic [9:0] v_next;

    // Position of the following cycle; all flags are derived from it so they line up
    always_comb begin
        h_next = o_video.hpos + 10'd1;
        v_next = o_video.vpos;
        if (o_video.hpos == rbz_pkg::H_TOTAL - 10'd1) begin
            h_next = 10'd0;
            if (o_video.vpos == rbz_pkg::V_TOTAL - 10'd1) begin
                v_next = 10'd0; // Wrap to top of frame
            end else begin
                v_next = o_video.vpos + 10'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rbzero_reset) begin
            o_video.hpos        <= 10'd0;
            o_video.vpos        <= 10'd0;
            o_video.hblank      <= 1'b0;
            o_video.vblank      <= 1'b0;
            o_video.hsync_n     <= 1'b1;
            o_video.vsync_n     <= 1'b1;
            o_video.frame_start <= 1'b1; // First cycle out of reset is (0,0)
        end else begin
            o_video.hpos        <= h_next;
            o_video.vpos        <= v_next;
            o_video.hblank      <= (h_next >= rbz_pkg::H_ACTIVE);
            o_video.vblank      <= (v_next >= rbz_pkg::V_ACTIVE);
            o_video.hsync_n     <= ~((h_next >= rbz_pkg::H_SYNC_START) &&
                                     (h_next <  rbz_pkg::H_SYNC_END));
            o_video.vsync_n     <= ~((v_next >= rbz_pkg::V_SYNC_START) &&
                                     (v_next <  rbz_pkg::V_SYNC_END));
            o_video.frame_start <= (h_next == 10'd0) && (v_next == 10'd0);
        end
        o_video.spare <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== src/spi_reg_periph.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_reg_periph (
    input  logic                 i_clk,
    input  logic                 i_rbzero_reset,
    input  logic                 i_spi_csb,
    input  logic                 i_spi_sclk,
    input  logic                 i_spi_mosi,
    output rbz_pkg::render_cfg_t o_cfg
);

    typedef enum logic [1:0] {
        ST_IDLE,   // Waiting for csb to fall
        ST_SHIFT,  // Frame in progress
        ST_COMMIT  // Good frame, write on this cycle
    } spi_state_e;

    // [0] and [1] are the synchroniser, [2] holds the previous synced value
    logic [2:0] csb_sync;
    logic [2:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic       csb_fall;
    logic       csb_rise;
    logic       sclk_rise;

    spi_state_e                          state;
    logic [3:0]                          bit_cnt;
    logic [rbz_pkg::SPI_FRAME_BITS-1:0]  shift_q;
    rbz_pkg::reg_addr_e                  wr_addr;
    logic [7:0]                          wr_data;

    always_ff @(posedge i_clk) begin
        if (i_rbzero_reset) begin
            csb_sync  <= 3'b111; // Bus idles deselected
            sclk_sync <= 3'b000;
            mosi_sync <= 2'b00;
        end else begin
            csb_sync  <= {csb_sync[1:0], i_spi_csb};
            sclk_sync <= {sclk_sync[1:0], i_spi_sclk};
            mosi_sync <= {mosi_sync[0], i_spi_mosi};
        end
    end

    assign csb_fall  = ~csb_sync[1] &  csb_sync[2];
    assign csb_rise  =  csb_sync[1] & ~csb_sync[2];
    assign sclk_rise =  sclk_sync[1] & ~sclk_sync[2];

    // MSB first: address lands in the top nibble
    always_ff @(posedge i_clk) begin
        if (state == ST_SHIFT && !csb_rise && sclk_rise) begin
            shift_q <= {shift_q[rbz_pkg::SPI_FRAME_BITS-2:0], mosi_sync[1]};
        end
    end

    assign wr_addr = rbz_pkg::reg_addr_e'(shift_q[11:8]);
    assign wr_data = shift_q[7:0];

    always_ff @(posedge i_clk) begin
        if (i_rbzero_reset) begin
            state   <= ST_IDLE;
            bit_cnt <= 4'd0;
            o_cfg   <= rbz_pkg::RENDER_CFG_RESET;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (csb_fall) begin
                        state   <= ST_SHIFT;
                        bit_cnt <= 4'd0;
                    end
                end
                ST_SHIFT: begin
                    if (csb_rise) begin // Only an exact-length frame is kept
                        state <= (bit_cnt == rbz_pkg::SPI_FRAME_BITS) ? ST_COMMIT : ST_IDLE;
                    end else if (sclk_rise && bit_cnt != 4'hf) begin
                        bit_cnt <= bit_cnt + 4'd1; // Saturates so long frames never alias
                    end
                end
                ST_COMMIT: begin
                    case (wr_addr)
                        rbz_pkg::REG_MODE:        o_cfg.mode <= rbz_pkg::render_mode_e'(wr_data[1:0]);
                        rbz_pkg::REG_FG:          o_cfg.fg <= wr_data[5:0];
                        rbz_pkg::REG_BG:          o_cfg.bg <= wr_data[5:0];
                        rbz_pkg::REG_CHECK_SHIFT: o_cfg.check_shift <= wr_data[2:0];
                        default: ; // Unknown address, dropped
                    endcase
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/pattern_render.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_render (
    input  logic                 i_clk,
    input  logic                 i_rbzero_reset,
    input  rbz_pkg::video_t      i_video,
    input  rbz_pkg::render_cfg_t i_cfg,
    output logic [5:0]           o_bgr
);

    rbz_pkg::render_cfg_t cfg_q; // Config in force for the current frame
    logic [9:0]           hx;
    logic [9:0]           vy;
    logic [2:0]           bar_en;
    logic [5:0]           colour;

    // New settings only take effect at the top of a frame, so no tearing
    always_ff @(posedge i_clk) begin
        if (i_rbzero_reset) begin
            cfg_q <= rbz_pkg::RENDER_CFG_RESET;
        end else if (i_video.frame_start) begin
            cfg_q <= i_cfg;
        end
    end

    assign hx     = i_video.hpos >> cfg_q.check_shift;
    assign vy     = i_video.vpos >> cfg_q.check_shift;
    assign bar_en = i_video.hpos[8:6]; // Red, green, blue enables, new bar every 64 px

    always_comb begin
        case (cfg_q.mode)
            rbz_pkg::RENDER_SOLID: colour = cfg_q.fg;
            rbz_pkg::RENDER_BARS: begin
                colour = {{2{bar_en[0]}},  // Blue
                          {2{bar_en[1]}},  // Green
                          {2{bar_en[2]}}}; // Red
            end
            rbz_pkg::RENDER_CHECKER: begin
                colour = (hx[0] ^ vy[0]) ? cfg_q.fg : cfg_q.bg;
            end
            default: colour = cfg_q.bg;
        endcase
    end

    // Black outside the visible area
    assign o_bgr = (i_video.hblank || i_video.vblank) ? 6'd0 : colour;

endmodule

`default_nettype wire

// ==== src/gpout_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpout_mux (
    input  logic                i_clk,
    input  logic                i_rbzero_reset,
    input  rbz_pkg::gpout_sel_e i_sel,
    input  logic                i_primary,   // Code 0
    input  logic                i_alt,       // Code 1
    input  rbz_pkg::probe_bus_t i_probe,
    output logic                o_gpout
);

    logic [1:0] clk_div;
    logic [5:0] rgb_idx;
    logic [5:0] hpos_idx;
    logic [5:0] vpos_idx;

    // Free-running, bit 1 is clk/4
    always_ff @(posedge i_clk) begin
        if (i_rbzero_reset) begin
            clk_div <= 2'd0;
        end else begin
            clk_div <= clk_div + 2'd1;
        end
    end

    // Offsets into the wide probe fields
    assign rgb_idx  = i_sel - rbz_pkg::GP_RGB_BASE;
    assign hpos_idx = i_sel - rbz_pkg::GP_HPOS_BASE;
    assign vpos_idx = i_sel - rbz_pkg::GP_VPOS_BASE;

    always_comb begin
        case (i_sel) inside
            rbz_pkg::GP_PRIMARY:  o_gpout = i_primary;
            rbz_pkg::GP_ALT:      o_gpout = i_alt;
            rbz_pkg::GP_CLK:      o_gpout = i_clk;
            rbz_pkg::GP_CLK_DIV4: o_gpout = clk_div[1];
            rbz_pkg::GP_SPI_CSB:  o_gpout = i_probe.spi_csb;
            rbz_pkg::GP_SPI_SCLK: o_gpout = i_probe.spi_sclk;
            rbz_pkg::GP_SPI_MOSI: o_gpout = i_probe.spi_mosi;
            [6'd8:6'd31]:         o_gpout = i_probe.rgb[rgb_idx[4:0]];
            rbz_pkg::GP_HBLANK:   o_gpout = i_probe.hblank;
            rbz_pkg::GP_VBLANK:   o_gpout = i_probe.vblank;
            rbz_pkg::GP_HSYNC:    o_gpout = i_probe.hsync_n;
            rbz_pkg::GP_VSYNC:    o_gpout = i_probe.vsync_n;
            [6'd44:6'd53]:        o_gpout = i_probe.hpos[hpos_idx[3:0]];
            [6'd54:6'd63]:        o_gpout = i_probe.vpos[vpos_idx[3:0]];
            default:              o_gpout = 1'b0; // Unused codes 7, 36..43
        endcase
    end

endmodule

`default_nettype wire

// ==== src/pad_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pad_ctrl (
    input  logic            i_clk,
    input  logic            i_reset_lock_a,
    input  logic            i_reset_lock_b,
    input  logic            i_reg_outs_enb,  // 1 direct, 0 registered
    input  logic [5:0]      i_bgr,
    input  rbz_pkg::video_t i_video,
    input  logic [5:0]      i_gpout,
    output logic            o_rbzero_reset,
    output logic [23:0]     o_rgb_direct,
    output logic            o_hsync,
    output logic            o_vsync,
    output logic [23:0]     o_rgb,
    output logic [5:0]      o_gpout
);

    typedef struct packed {
        logic        hsync;
        logic        vsync;
        logic [23:0] rgb;
        logic [5:0]  gpout;
    } pad_out_t;

    logic     rbzero_reset;
    pad_out_t outs_direct;
    pad_out_t outs_q;
    pad_out_t outs;

    // Held in reset unless the lock pins disagree
    always_ff @(posedge i_clk) begin
        rbzero_reset <= ~(i_reset_lock_a ^ i_reset_lock_b);
    end
    assign o_rbzero_reset = rbzero_reset;

    // 2 bits per channel into the top of each DAC byte
    assign o_rgb_direct = {i_bgr[5:4], 6'b0, i_bgr[3:2], 6'b0, i_bgr[1:0], 6'b0};

    assign outs_direct = '{
        hsync: i_video.hsync_n,
        vsync: i_video.vsync_n,
        rgb:   o_rgb_direct,
        gpout: i_gpout
    };

    always_ff @(posedge i_clk) begin
        if (rbzero_reset) begin
            outs_q <= '0;
        end else begin
            outs_q <= outs_direct; // One stage to clean up the pad timing
        end
    end

    assign outs = i_reg_outs_enb ? outs_direct : outs_q;

    assign o_hsync = outs.hsync;
    assign o_vsync = outs.vsync;
    assign o_rgb   = outs.rgb;
    assign o_gpout = outs.gpout;

endmodule

`default_nettype wire

// ==== src/ew_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ew_top (
    input  logic            clk,
    input  logic            i_reset_lock_a,
    input  logic            i_reset_lock_b,
    output logic            o_reset,        // Internal reset, for debug
    input  logic            i_spi_csb,      // Register port
    input  logic            i_spi_sclk,
    input  logic            i_spi_mosi,
    input  logic            i_reg_outs_enb,
    input  logic [5:0][5:0] i_gpout_sel,    // One selector code per gpout
    input  logic [5:0]      i_alt,
    output logic [5:0]      o_gpout,
    output logic            o_hsync,
    output logic            o_vsync,
    output logic [23:0]     o_rgb           // BGR888
);

    logic                 rbzero_reset;
    rbz_pkg::video_t      video;
    rbz_pkg::render_cfg_t cfg;
    logic [5:0]           bgr;
    logic [23:0]          rgb_direct;
    logic [5:0]           gpout_direct;
    rbz_pkg::probe_bus_t  probe;

    assign o_reset = rbzero_reset;

    vga_sync vga_sync_inst (
        .i_clk          (clk),
        .i_rbzero_reset (rbzero_reset),
        .o_video        (video)
    );

    spi_reg_periph spi_reg_periph_inst (
        .i_clk          (clk),
        .i_rbzero_reset (rbzero_reset),
        .i_spi_csb      (i_spi_csb),
        .i_spi_sclk     (i_spi_sclk),
        .i_spi_mosi     (i_spi_mosi),
        .o_cfg          (cfg)
    );

    pattern_render pattern_render_inst (
        .i_clk          (clk),
        .i_rbzero_reset (rbzero_reset),
        .i_video        (video),
        .i_cfg          (cfg),
        .o_bgr          (bgr)
    );

    // Shared probe signals, rgb comes back from the pad block unregistered
    assign probe = '{
        spi_csb:  i_spi_csb,
        spi_sclk: i_spi_sclk,
        spi_mosi: i_spi_mosi,
        hblank:   video.hblank,
        vblank:   video.vblank,
        hsync_n:  video.hsync_n,
        vsync_n:  video.vsync_n,
        hpos:     video.hpos,
        vpos:     video.vpos,
        rgb:      rgb_direct
    };

    for (genvar k = 0; k < 6; k++) begin : g_gpout
        gpout_mux gpout_mux_inst (
            .i_clk          (clk),
            .i_rbzero_reset (rbzero_reset),
            .i_sel          (rbz_pkg::gpout_sel_e'(i_gpout_sel[k])),
            .i_primary      (bgr[rbz_pkg::GP_PRIMARY_BIT[k]]),
            .i_alt          (i_alt[k]),
            .i_probe        (probe),
            .o_gpout        (gpout_direct[k])
        );
    end

    pad_ctrl pad_ctrl_inst (
        .i_clk          (clk),
        .i_reset_lock_a (i_reset_lock_a),
        .i_reset_lock_b (i_reset_lock_b),
        .i_reg_outs_enb (i_reg_outs_enb),
        .i_bgr          (bgr),
        .i_video        (video),
        .i_gpout        (gpout_direct),
        .o_rbzero_reset (rbzero_reset),
        .o_rgb_direct   (rgb_direct),
        .o_hsync        (o_hsync),
        .o_vsync        (o_vsync),
        .o_rgb          (o_rgb),
        .o_gpout        (o_gpout)
    );

endmodule

`default_nettype wire

// ==== bench/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] take_random(input int nbits);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        value      = {value[30:0], fb};
    end
    return value;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
        error_count++;
        $display("error: %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
endtask

// Next point where inputs may change
task automatic drive_point(input int n);
    repeat (n) @(posedge clk);
    #(DRIVE_DELAY);
endtask

// One pixel per cycle, sampled mid-period
task automatic step_pixel();
    @(negedge clk);
    pos_h++;
    if (pos_h == LINE_CYCLES) begin
        pos_h = 0;
        pos_v = (pos_v == FRAME_LINES - 1) ? 0 : pos_v + 1;
    end
endtask

function automatic logic sync_level(input bit vertical);
    return vertical ? o_vsync : o_hsync;
endfunction

task automatic wait_sync_fall(input bit vertical, input int limit, output bit found);
    logic prev;
    found = 1'b0;
    @(negedge clk);
    prev = sync_level(vertical);
    for (int n = 0; n < limit && !found; n++) begin
        @(negedge clk);
        found = prev && !sync_level(vertical);
        prev  = sync_level(vertical);
    end
    if (!found) begin
        error_count++;
        $display("timeout: %s sync did not fall within %0d cycles",
                 vertical ? "vertical" : "horizontal", limit);
    end
endtask

// Low time and period in cycles, both counted from a falling edge
task automatic measure_sync(input bit vertical, output int low_time, output int period);
    bit found;
    bit rose;
    int n;
    low_time = 0;
    period   = 0;
    rose     = 1'b0;
    n        = 0;
    wait_sync_fall(vertical, FRAME_CYCLES + LINE_CYCLES, found);
    while (found && period == 0 && n < FRAME_CYCLES + LINE_CYCLES) begin
        @(negedge clk);
        n++;
        if (!rose && sync_level(vertical)) begin
            rose     = 1'b1;
            low_time = n;
        end else if (rose && !sync_level(vertical)) begin
            period = n;
        end
    end
endtask

// Colour of one pixel as it should leave the chip, BGR888
function automatic logic [23:0] expected_rgb(input int h, input int v, input logic [1:0] mode,
                                            input logic [5:0] fg, input logic [5:0] bg,
                                            input int shift);
    logic [5:0] c;
    logic [9:0] hv;
    logic [9:0] vv;
    hv = 10'(h);
    vv = 10'(v);
    case (mode)
        rbz_pkg::RENDER_SOLID:   c = fg;
        rbz_pkg::RENDER_BARS:    c = {{2{hv[6]}}, {2{hv[7]}}, {2{hv[8]}}}; // B, G, R enables
        rbz_pkg::RENDER_CHECKER: c = (hv[shift] ^ vv[shift]) ? fg : bg;
        default:                 c = bg;
    endcase
    if (h >= H_ACTIVE || v >= V_ACTIVE) begin
        c = 6'd0;
    end
    return {c[5:4], 6'd0, c[3:2], 6'd0, c[1:0], 6'd0};
endfunction

task automatic align_frame();
    bit found;
    wait_sync_fall(1'b1, FRAME_CYCLES + LINE_CYCLES, found);
    pos_h = 0; // vsync falls as the counters reach line 490
    pos_v = V_SYNC_START;
endtask

// Checks vblank and the first lines of the next frame, stops entering (0, lines)
task automatic scan_frame(input string name, input logic [1:0] mode, input logic [5:0] fg,
                          input logic [5:0] bg, input int shift, input int lines);
    align_frame();
    do begin
        step_pixel();
        if (!(pos_h == 0 && pos_v == 0)) begin // Config is latched at the end of (0,0)
            check_value(name, expected_rgb(pos_h, pos_v, mode, fg, bg, shift), o_rgb);
        end
    end while (pos_v != lines);
endtask

task automatic spi_write(input logic [3:0] addr, input logic [7:0] data, input int nbits);
    logic [11:0] word;
    word = {addr, data};
    drive_point(1);
    i_spi_csb = 1'b0;
    drive_point(SPI_HOLD);
    for (int i = 11; i > 11 - nbits; i--) begin // MSB first
        i_spi_mosi = word[i];
        drive_point(SPI_HOLD);
        i_spi_sclk = 1'b1;
        drive_point(SPI_HOLD);
        i_spi_sclk = 1'b0;
    end
    drive_point(SPI_HOLD);
    i_spi_csb = 1'b1;
    drive_point(SPI_HOLD + 4); // Commit lands 4 cycles after csb rises
endtask

// Runs on a bars frame with the position counter in step
task automatic test_reset_lock();
    while (pos_h != 100) begin // Inside a lit bar, so the output register holds colour
        step_pixel();
    end
    drive_point(1);
    i_reg_outs_enb = 1'b0;
    i_gpout_sel    = {6{6'(rbz_pkg::GP_SPI_CSB)}}; // Idle csb is 1 on the direct path
    i_reset_lock_b = 1'b1;                         // Pins now equal
    @(negedge clk);
    check_value("reset_lock before edge", 1'b0, o_reset);
    @(negedge clk);
    check_value("reset_lock assert", 1'b1, o_reset);
    @(negedge clk);
    check_value("reset_lock hsync", 1'b0, o_hsync);
    check_value("reset_lock vsync", 1'b0, o_vsync);
    check_value("reset_lock rgb", 24'd0, o_rgb);
    check_value("reset_lock gpout", 6'd0, o_gpout);
    drive_point(1);
    i_reset_lock_a = 1'b0;
    @(negedge clk);
    check_value("reset_lock held", 1'b1, o_reset);
    @(negedge clk);
    check_value("reset_lock release", 1'b0, o_reset);
    drive_point(1);
    i_reg_outs_enb = 1'b1;
    i_gpout_sel    = {6{6'(rbz_pkg::GP_PRIMARY)}};
endtask

task automatic test_selector_loopback();
    logic [5:0]  alt;
    logic [11:0] div_seq;
    logic [1:0]  pins;
    drive_point(1);
    i_gpout_sel = {6{6'(rbz_pkg::GP_ALT)}};
    repeat (8) begin
        alt = 6'(take_random(6));
        drive_point(1);
        i_alt = alt;
        @(negedge clk);
        check_value("gp_alt", alt, o_gpout);
    end
    drive_point(1);
    i_gpout_sel = {6{6'(rbz_pkg::GP_CLK_DIV4)}};
    for (int i = 0; i < 12; i++) begin
        @(negedge clk);
        div_seq[i] = o_gpout[0];
        check_value("clk_div4 lanes agree", {6{o_gpout[0]}}, o_gpout);
    end
    for (int i = 0; i < 8; i++) begin
        check_value("clk_div4 period", div_seq[i], div_seq[i + 4]);
        check_value("clk_div4 half period", !div_seq[i], div_seq[i + 2]);
    end
    drive_point(1);
    i_gpout_sel = {6'(rbz_pkg::GP_SPI_MOSI), 6'(rbz_pkg::GP_SPI_SCLK), 6'(rbz_pkg::GP_SPI_CSB),
                   6'(rbz_pkg::GP_SPI_MOSI), 6'(rbz_pkg::GP_SPI_SCLK), 6'(rbz_pkg::GP_SPI_CSB)};
    for (int i = 0; i < 10; i++) begin
        pins = 2'(take_random(2));
        drive_point(1);
        i_spi_sclk = (i < 8) ? pins[1] : 1'b0;
        i_spi_mosi = pins[0];
        i_spi_csb  = (i != 8);     // Short csb pulse with no clocks, dropped by the DUT
        @(negedge clk);
        check_value("gp_spi pins", {2{i_spi_mosi, i_spi_sclk, i_spi_csb}}, o_gpout);
    end
    drive_point(1);
    i_spi_mosi = 1'b0;
endtask

task automatic test_sync_timing();
    int low_time;
    int period;
    bit found;
    for (int base = 0; base <= 4; base += 4) begin
        drive_point(1);
        for (int k = 0; k < 6; k++) begin
            i_gpout_sel[k] = 6'(rbz_pkg::GP_HPOS_BASE + base + k);
        end
        wait_sync_fall(1'b0, 2 * LINE_CYCLES, found);
        pos_h = H_SYNC_START;
        repeat (LINE_CYCLES) begin
            step_pixel();
            check_value("hpos via gpout", (pos_h >> base) & 'h3f, o_gpout);
        end
    end
    measure_sync(1'b0, low_time, period);
    check_value("hsync low time", 96, low_time);
    check_value("hsync period", LINE_CYCLES, period);
    measure_sync(1'b1, low_time, period);
    check_value("vsync low time", 2 * LINE_CYCLES, low_time);
    check_value("vsync period", FRAME_CYCLES, period);
endtask

task automatic test_solid_checker();
    logic [5:0] fg;
    logic [5:0] bg;
    fg = 6'(take_random(6));
    bg = 6'(take_random(6));
    if (fg == 6'd0) begin
        fg = 6'h2a; // Black would look the same as blanking
    end
    if (bg == fg) begin
        bg = ~fg;
    end
    spi_write(rbz_pkg::REG_FG, {2'b00, fg}, 12);
    spi_write(rbz_pkg::REG_BG, {2'b00, bg}, 12);
    spi_write(rbz_pkg::REG_MODE, 8'(rbz_pkg::RENDER_SOLID), 12);
    scan_frame("solid", rbz_pkg::RENDER_SOLID, fg, bg, 3, 2);
    spi_write(rbz_pkg::REG_CHECK_SHIFT, 8'd3, 12);
    spi_write(rbz_pkg::REG_MODE, 8'(rbz_pkg::RENDER_CHECKER), 12);
    scan_frame("checker", rbz_pkg::RENDER_CHECKER, fg, bg, 3, 17); // Two rows of squares
endtask

task automatic test_bars_discard();
    spi_write(rbz_pkg::REG_MODE, 8'(rbz_pkg::RENDER_BARS), 12);
    scan_frame("bars", rbz_pkg::RENDER_BARS, 6'd0, 6'd0, 0, 2);
    // Ends on a 0 bit, so the short frame below would decode as a REG_MODE write if kept
    spi_write(rbz_pkg::REG_CHECK_SHIFT, 8'd2, 12);
    spi_write(rbz_pkg::REG_MODE, 8'(rbz_pkg::RENDER_SOLID), 11); // One bit short
    scan_frame("bars after short frame", rbz_pkg::RENDER_BARS, 6'd0, 6'd0, 0, 2);
endtask

// Line 1 direct, line 2 registered, edges located against the position counter
task automatic test_registered_output();
    int          fall_h [2];
    int          change_h [2];
    logic [23:0] prev_rgb;
    logic        prev_hs;
    scan_frame("direct lead-in", rbz_pkg::RENDER_BARS, 6'd0, 6'd0, 0, 1);
    for (int phase = 0; phase < 2; phase++) begin
        fall_h[phase]   = -1;
        change_h[phase] = -1;
        prev_rgb        = o_rgb;
        prev_hs         = o_hsync;
        do begin
            step_pixel();
            if (change_h[phase] < 0 && o_rgb !== prev_rgb) begin
                change_h[phase] = pos_h;
            end
            if (prev_hs && !o_hsync) begin
                fall_h[phase] = pos_h;
            end
            prev_rgb = o_rgb;
            prev_hs  = o_hsync;
            if (phase == 0 && pos_h == 700) begin // Deep in hblank, sync already low
                drive_point(1);
                i_reg_outs_enb = 1'b0;
            end
        end while (pos_h != 0);
    end
    check_value("direct hsync fall hpos", H_SYNC_START, fall_h[0]);
    check_value("registered hsync fall hpos", H_SYNC_START + 1, fall_h[1]);
    check_value("direct first rgb change hpos", 64, change_h[0]);
    check_value("registered first rgb change hpos", 65, change_h[1]);
    drive_point(1);
    i_reg_outs_enb = 1'b1;
endtask

`endif

// ==== bench/tb_ew_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ew_top;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int SPI_HOLD     = 4;      // clk cycles per sclk level
    localparam int LINE_CYCLES  = 800;
    localparam int FRAME_LINES  = 525;
    localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
    localparam int H_ACTIVE     = 640;
    localparam int V_ACTIVE     = 480;
    localparam int H_SYNC_START = 656;
    localparam int V_SYNC_START = 490;
    localparam int FRAME_STEPS  = 6;      // vsync measure, five frame scans
    // Up to two frames per step, one more as slack
    localparam longint WATCHDOG_NS = (2 * FRAME_STEPS + 1) * FRAME_CYCLES * CLK_PERIOD;

    logic            clk;
    logic            i_reset_lock_a;
    logic            i_reset_lock_b;
    logic            o_reset;
    logic            i_spi_csb;
    logic            i_spi_sclk;
    logic            i_spi_mosi;
    logic            i_reg_outs_enb;
    logic [5:0][5:0] i_gpout_sel;
    logic [5:0]      i_alt;
    logic [5:0]      o_gpout;
    logic            o_hsync;
    logic            o_vsync;
    logic [23:0]     o_rgb;

    int          error_count;
    int          check_count;
    logic [31:0] lfsr_state;
    int          pos_h;       // Position the DUT should be showing
    int          pos_v;

    ew_top ew_top_inst (
        .clk            (clk),
        .i_reset_lock_a (i_reset_lock_a),
        .i_reset_lock_b (i_reset_lock_b),
        .o_reset        (o_reset),
        .i_spi_csb      (i_spi_csb),
        .i_spi_sclk     (i_spi_sclk),
        .i_spi_mosi     (i_spi_mosi),
        .i_reg_outs_enb (i_reg_outs_enb),
        .i_gpout_sel    (i_gpout_sel),
        .i_alt          (i_alt),
        .o_gpout        (o_gpout),
        .o_hsync        (o_hsync),
        .o_vsync        (o_vsync),
        .o_rgb          (o_rgb)
    );

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        error_count    = 0;
        check_count    = 0;
        lfsr_state     = 32'h8d18_4b50;
        pos_h          = 0;
        pos_v          = 0;
        i_reset_lock_a = 1'b0; // Equal pins, design held in reset
        i_reset_lock_b = 1'b0;
        i_spi_csb      = 1'b1;
        i_spi_sclk     = 1'b0;
        i_spi_mosi     = 1'b0;
        i_reg_outs_enb = 1'b1;
        i_gpout_sel    = {6{6'(rbz_pkg::GP_PRIMARY)}};
        i_alt          = 6'd0;
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        i_reset_lock_a = 1'b1;

        test_selector_loopback();
        test_sync_timing();
        test_solid_checker();
        test_bars_discard();
        test_registered_output();
        test_reset_lock();

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+bench
src/rbz_pkg.sv
src/vga_sync.sv
src/spi_reg_periph.sv
src/pattern_render.sv
src/gpout_mux.sv
src/pad_ctrl.sv
src/ew_top.sv
bench/tb_ew_top.sv
